// ==== verilog.f ====
+incdir+hw
hw/decodePkg.sv
hw/instrMatch.sv
hw/immGen.sv
hw/decodeStage.sv
hw/decodeQueue.sv
hw/issueStage.sv
hw/decoderTop.sv
dv/decoderTb.sv

// ==== Makefile ====
VERILATOR ?= verilator
FLAGS     ?= --binary --timing -j 0
TOP       ?= decoderTb
FILELIST  ?= verilog.f
OBJDIR    ?= obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJDIR)

run: build
	./$(OBJDIR)/V$(TOP)

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJDIR)

// ==== dv/decoderTb.sv ====
//////////////////////////////
// Decode pipeline testbench
// Swept and random instruction words through
// both credit loops, checked against a
// reference decoder
//////////////////////////////

`timescale 1ns/1ns

`include "decode_params.svh"

module decoderTb;

  import decodePkg::*;

  localparam int NUM_SWEEP = 13 * 8 * 3 + 2;  // Opcode x funct3 x funct7, plus ECALL and EBREAK
  localparam int NUM_RANDOM = 400;
  localparam int NUM_INSTR = NUM_SWEEP + NUM_RANDOM;
  localparam int STALL_MAX = 12;  // Longest output stall in cycles
  localparam int WATCHDOG_CYCLES = NUM_INSTR * 20 + 200;

  typedef struct {
    xlen_t  pc;
    instr_t code;
    int     sendEdge;  // Clock edge that sampled the word
    bit     fast;      // Sent while output credits came back at once
  } sentInstr_t;

  localparam logic [6:0] OPS [13] = '{7'h37, 7'h17, 7'h6F, 7'h67, 7'h63, 7'h03, 7'h23,
                                     7'h13, 7'h1B, 7'h33, 7'h3B, 7'h0F, 7'h73};
  localparam logic [6:0] F7S [3] = '{7'h00, 7'h01, 7'h20};
  localparam logic [6:0] DROPPED [5] = '{7'h2F, 7'h07, 7'h27, 7'h43, 7'h53};  // A, F and D

  // Function per funct3
  localparam func_t BR_FN [8] = '{FUNC_BEQ, FUNC_BNE, FUNC_INVALID, FUNC_INVALID,
                                  FUNC_BLT, FUNC_BGE, FUNC_BLTU, FUNC_BGEU};
  localparam func_t LD_FN [8] = '{FUNC_LB, FUNC_LH, FUNC_LW, FUNC_LD,
                                  FUNC_LBU, FUNC_LHU, FUNC_LWU, FUNC_INVALID};
  localparam func_t ST_FN [8] = '{FUNC_SB, FUNC_SH, FUNC_SW, FUNC_SD,
                                  FUNC_INVALID, FUNC_INVALID, FUNC_INVALID, FUNC_INVALID};
  localparam func_t OPI_FN [8] = '{FUNC_ADDI, FUNC_SLLI, FUNC_SLTI, FUNC_SLTIU,
                                   FUNC_XORI, FUNC_SRLI, FUNC_ORI, FUNC_ANDI};
  localparam func_t OP_FN [8] = '{FUNC_ADD, FUNC_SLL, FUNC_SLT, FUNC_SLTU,
                                  FUNC_XOR, FUNC_SRL, FUNC_OR, FUNC_AND};
  localparam func_t MUL_FN [8] = '{FUNC_MUL, FUNC_MULH, FUNC_MULHSU, FUNC_MULHU,
                                   FUNC_DIV, FUNC_DIVU, FUNC_REM, FUNC_REMU};
  localparam func_t MULW_FN [8] = '{FUNC_MULW, FUNC_INVALID, FUNC_INVALID, FUNC_INVALID,
                                    FUNC_DIVW, FUNC_DIVUW, FUNC_REMW, FUNC_REMUW};
  localparam func_t CSR_FN [8] = '{FUNC_INVALID, FUNC_CSRRW, FUNC_CSRRS, FUNC_CSRRC,
                                   FUNC_INVALID, FUNC_CSRRWI, FUNC_CSRRSI, FUNC_CSRRCI};

  logic     i_clk;
  logic     i_arstN;
  logic     i_instrValid;
  xlen_t    i_pc;
  instr_t   i_code;
  logic     i_outCredit;
  logic     o_inCredit;
  logic     o_cmdValid;
  func_t    o_func;
  regIdx_t  o_rd;
  regIdx_t  o_rs1;
  regIdx_t  o_rs2;
  xlen_t    o_imm;
  xlen_t    o_pc;
  logic     o_jump;
  regMask_t o_regReq;

  int         cycle = 0;
  int         inCredits = `DEC_QUEUE_DEPTH;
  int         checked = 0;
  bit         fastMode = 1'b1;
  sentInstr_t expQ [$];

  decoderTop decoderTop_i (
    .i_clk        (i_clk),
    .i_arstN      (i_arstN),
    .i_instrValid (i_instrValid),
    .i_pc         (i_pc),
    .i_code       (i_code),
    .i_outCredit  (i_outCredit),
    .o_inCredit   (o_inCredit),
    .o_cmdValid   (o_cmdValid),
    .o_func       (o_func),
    .o_rd         (o_rd),
    .o_rs1        (o_rs1),
    .o_rs2        (o_rs2),
    .o_imm        (o_imm),
    .o_pc         (o_pc),
    .o_jump       (o_jump),
    .o_regReq     (o_regReq)
  );

  initial begin : clockGen
    i_clk = 1'b0;
    forever #5 i_clk = ~i_clk;
  end

  always @(posedge i_clk) cycle <= cycle + 1;

  task automatic checkValue(input string name, input logic [63:0] expected,
                            input logic [63:0] actual);
    if (expected !== actual) begin
      $display("Error at %0t ns: %s expected 0x%0h, got 0x%0h", $time, name, expected, actual);
      $display("TEST FAILED");
      $fatal(1, "Mismatch on %s", name);
    end
  endtask

  //////////////////////////////
  // Reference decoder
  //////////////////////////////
  function automatic void decodeRef(input xlen_t pc, input instr_t code,
                                    output decodedInstr_t rec, output regMask_t req);
    logic [6:0] op;
    logic [2:0] f3;
    logic [6:0] f7;
    func_t      f;
    immSel_t    sel;
    logic [3:0] flags;  // {rd, rs1, rs2, jump}
    xlen_t      imm;
    op = code[6:0];
    f3 = code[14:12];
    f7 = code[31:25];
    f = FUNC_INVALID;
    case (op)
      7'h37: f = FUNC_LUI;
      7'h17: f = FUNC_AUIPC;
      7'h6F: f = FUNC_JAL;
      7'h67: f = (f3 == 3'd0) ? FUNC_JALR : FUNC_INVALID;
      7'h63: f = BR_FN[f3];
      7'h03: f = LD_FN[f3];
      7'h23: f = ST_FN[f3];
      7'h0F: f = (f3 == 3'd0) ? FUNC_FENCE : FUNC_INVALID;  // TSO and PAUSE land here too
      7'h13: begin
        f = OPI_FN[f3];
        if (f3 == 3'd1 && f7[6:1] != 6'h00) f = FUNC_INVALID;  // Bit 25 is shamt[5]
        if (f3 == 3'd5 && f7[6:1] == 6'h10) f = FUNC_SRAI;
        else if (f3 == 3'd5 && f7[6:1] != 6'h00) f = FUNC_INVALID;
      end
      7'h1B: begin
        if (f3 == 3'd0) f = FUNC_ADDIW;
        if (f3 == 3'd1 && f7 == 7'h00) f = FUNC_SLLIW;
        if (f3 == 3'd5 && f7 == 7'h00) f = FUNC_SRLIW;
        if (f3 == 3'd5 && f7 == 7'h20) f = FUNC_SRAIW;
      end
      7'h33: begin
        if (f7 == 7'h00) f = OP_FN[f3];
        if (f7 == 7'h01) f = MUL_FN[f3];
        if (f7 == 7'h20 && f3 == 3'd0) f = FUNC_SUB;
        if (f7 == 7'h20 && f3 == 3'd5) f = FUNC_SRA;
      end
      7'h3B: begin
        if (f7 == 7'h01) f = MULW_FN[f3];
        if (f7 == 7'h00 && f3 == 3'd0) f = FUNC_ADDW;
        if (f7 == 7'h00 && f3 == 3'd1) f = FUNC_SLLW;
        if (f7 == 7'h00 && f3 == 3'd5) f = FUNC_SRLW;
        if (f7 == 7'h20 && f3 == 3'd0) f = FUNC_SUBW;
        if (f7 == 7'h20 && f3 == 3'd5) f = FUNC_SRAW;
      end
      7'h73: begin
        f = CSR_FN[f3];
        if (code == 32'h0000_0073) f = FUNC_ECALL;
        if (code == 32'h0010_0073) f = FUNC_EBREAK;
      end
      default: f = FUNC_INVALID;
    endcase
    case (op)
      7'h37, 7'h17:        sel = IMM_U;
      7'h6F:               sel = IMM_J;
      7'h63:               sel = IMM_B;
      7'h23:               sel = IMM_S;
      7'h67, 7'h03, 7'h0F: sel = IMM_I;
      7'h13, 7'h1B:        sel = (f3 == 3'd1 || f3 == 3'd5) ? IMM_SHAMT : IMM_I;
      7'h73:               sel = IMM_CSR;
      default:             sel = IMM_NONE;
    endcase
    case (op)
      7'h37, 7'h17:        flags = 4'b1000;
      7'h6F:               flags = 4'b1001;
      7'h67:               flags = 4'b1101;
      7'h63:               flags = 4'b0111;
      7'h23:               flags = 4'b0110;
      7'h03, 7'h13, 7'h1B: flags = 4'b1100;
      7'h33, 7'h3B:        flags = 4'b1110;
      7'h73:               flags = f3[2] ? 4'b1000 : 4'b1100;  // uimm forms skip rs1
      default:             flags = 4'b0000;
    endcase
    if (f == FUNC_ECALL || f == FUNC_EBREAK) begin
      sel = IMM_NONE;
      flags = 4'b0001;
    end
    if (f == FUNC_INVALID) begin
      sel = IMM_NONE;
      flags = 4'b0000;
    end
    case (sel)
      IMM_SHAMT: imm = code[25:20];
      IMM_B:     imm = $signed({code[31], code[7], code[30:25], code[11:8], 1'b0});
      IMM_CSR:   imm = {code[19:15], code[31:20]};
      IMM_I:     imm = $signed(code[31:20]);
      IMM_J:     imm = $signed({code[31], code[19:12], code[20], code[30:21], 1'b0});
      IMM_S:     imm = $signed({code[31:25], code[11:7]});
      IMM_U:     imm = code[31:12];
      default:   imm = '0;
    endcase
    rec.func = f;
    rec.rd = flags[3] ? code[11:7] : '0;
    rec.rs1 = flags[2] ? code[19:15] : '0;
    rec.rs2 = flags[1] ? code[24:20] : '0;
    rec.imm = imm;
    rec.pc = pc;
    rec.jump = flags[0];
    req = flags[0] ? '1 : '0;
    req[rec.rd] = 1'b1;
    req[rec.rs1] = 1'b1;
    req[rec.rs2] = 1'b1;
  endfunction

  //////////////////////////////
  // Stimulus helpers
  //////////////////////////////
  function automatic instr_t buildWord(input logic [6:0] op, input logic [2:0] f3,
                                       input logic [6:0] f7);
    instr_t w;
    w = $urandom();
    w[6:0] = op;
    w[14:12] = f3;
    if (op inside {7'h13, 7'h1B, 7'h33, 7'h3B}) w[31:25] = f7;  // Else part of an immediate
    return w;
  endfunction

  function automatic instr_t randomWord();
    instr_t     w;
    int         kind;
    logic [6:0] f7;
    kind = $urandom_range(0, 15);
    f7 = (kind < 9) ? F7S[$urandom_range(0, 2)] : 7'($urandom());
    if (kind < 12) w = buildWord(OPS[$urandom_range(0, 12)], 3'($urandom()), f7);
    else if (kind < 15) w = buildWord(DROPPED[$urandom_range(0, 4)], 3'($urandom()), f7);
    else w = $urandom();
    if (kind == 0) w = 32'h0000_0073;
    if (kind == 1) w = 32'h0010_0073;
    return w;
  endfunction

  task automatic tickNeg();
    @(negedge i_clk);
    i_instrValid = 1'b0;
    if (o_inCredit) inCredits++;
    checkValue("o_inCredit", 64'(1'b1), 64'(inCredits <= `DEC_QUEUE_DEPTH));  // Too many back
  endtask

  task automatic sendWord(input instr_t code);
    sentInstr_t item;
    tickNeg();
    while (inCredits == 0 || $urandom_range(0, 7) == 0) tickNeg();  // Random pauses
    item.pc = {$urandom(), $urandom()};
    item.code = code;
    item.sendEdge = cycle + 1;
    item.fast = fastMode;
    expQ.push_back(item);
    inCredits--;
    i_pc = item.pc;
    i_code = code;
    i_instrValid = 1'b1;
  endtask

  task automatic idleUntil(input int count);
    while (checked < count) tickNeg();
  endtask

  initial begin : stimulus
    void'($urandom(44));
    i_arstN = 1'b0;
    i_instrValid = 1'b0;
    i_pc = '0;
    i_code = '0;
    repeat (8) @(posedge i_clk);
    @(negedge i_clk);
    i_arstN = 1'b1;
    repeat (5) begin  // Idle pipeline stays quiet
      @(negedge i_clk);
      checkValue("o_cmdValid", 64'(1'b0), 64'(o_cmdValid));
      checkValue("o_inCredit", 64'(1'b0), 64'(o_inCredit));
    end
    for (int o = 0; o < 13; o++)
      for (int f3 = 0; f3 < 8; f3++)
        for (int k = 0; k < 3; k++)
          sendWord(buildWord(OPS[o], 3'(f3), F7S[k]));
    sendWord(32'h0000_0073);
    sendWord(32'h0010_0073);
    idleUntil(NUM_SWEEP);
    fastMode = 1'b0;  // Output stalls from here on
    for (int n = 0; n < NUM_RANDOM; n++) sendWord(randomWord());
    idleUntil(NUM_INSTR);
    repeat (10) tickNeg();
    if (checked == NUM_INSTR && expQ.size() == 0) begin
      $display("TEST PASSED");
      $finish;
    end else begin
      $display("TEST FAILED");
      $fatal(1, "Command count does not match the instructions sent");
    end
  end

  //////////////////////////////
  // Output credits and checking
  //////////////////////////////
  initial begin : creditReturn
    int owed;
    int stall;
    owed = 0;
    stall = 0;
    i_outCredit = 1'b0;
    forever begin
      @(negedge i_clk);
      i_outCredit = 1'b0;
      if (o_cmdValid === 1'b1) owed++;
      checkValue("o_cmdValid", 64'(1'b1), 64'(owed <= `DEC_OUT_CREDITS));  // Spent past grants
      if (stall > 0) stall--;
      else if (owed > 0 && (fastMode || $urandom_range(0, 3) != 0)) begin
        i_outCredit = 1'b1;
        owed--;
      end
      if (!fastMode && stall == 0 && $urandom_range(0, 31) == 0)
        stall = $urandom_range(1, STALL_MAX);
    end
  end

  initial begin : compare
    sentInstr_t    item;
    decodedInstr_t exp;
    regMask_t      expReq;
    forever begin
      @(negedge i_clk);
      if (o_cmdValid === 1'b1 && expQ.size() == 0) begin
        $display("TEST FAILED");
        $fatal(1, "o_cmdValid pulsed with no instruction outstanding");
      end else if (o_cmdValid === 1'b1) begin
        item = expQ.pop_front();
        decodeRef(item.pc, item.code, exp, expReq);
        checkValue("o_func", 64'(exp.func), 64'(o_func));
        checkValue("o_rd", 64'(exp.rd), 64'(o_rd));
        checkValue("o_rs1", 64'(exp.rs1), 64'(o_rs1));
        checkValue("o_rs2", 64'(exp.rs2), 64'(o_rs2));
        checkValue("o_imm", exp.imm, o_imm);
        checkValue("o_pc", exp.pc, o_pc);
        checkValue("o_jump", 64'(exp.jump), 64'(o_jump));
        checkValue("o_regReq", 64'(expReq), 64'(o_regReq));
        if (item.fast) checkValue("o_cmdValid latency", 64'(2), 64'(cycle - item.sendEdge));
        checked++;
      end
    end
  end

  initial begin : watchdog
    repeat (WATCHDOG_CYCLES) @(posedge i_clk);
    $display("TEST FAILED");
    $fatal(1, "Timeout, the pipeline stopped delivering commands");
  end

endmodule

// ==== hw/decoderTop.sv ====
//////////////////////////////
// RV64 decode pipeline top
// Decode, queue and issue with credit flow
// control on both sides
//////////////////////////////

`timescale 1ns/1ns

module decoderTop (
  input  logic                i_clk,
  input  logic                i_arstN,
  input  logic                i_instrValid,
  input  decodePkg::xlen_t    i_pc,
  input  decodePkg::instr_t   i_code,
  input  logic                i_outCredit,
  output logic                o_inCredit,
  output logic                o_cmdValid,
  output decodePkg::func_t    o_func,
  output decodePkg::regIdx_t  o_rd,
  output decodePkg::regIdx_t  o_rs1,
  output decodePkg::regIdx_t  o_rs2,
  output decodePkg::xlen_t    o_imm,
  output decodePkg::xlen_t    o_pc,
  output logic                o_jump,
  output decodePkg::regMask_t o_regReq
);

  import decodePkg::*;

  logic          decValid;
  decodedInstr_t decInstr;
  logic          queueNotEmpty;
  decodedInstr_t queueHead;
  logic          issuePop;

  decodeStage decodeStage_i (
    .i_clk        (i_clk),
    .i_arstN      (i_arstN),
    .i_instrValid (i_instrValid),
    .i_pc         (i_pc),
    .i_code       (i_code),
    .o_valid      (decValid),
    .o_instr      (decInstr)
  );

  decodeQueue decodeQueue_i (
    .i_clk      (i_clk),
    .i_arstN    (i_arstN),
    .i_valid    (decValid),
    .i_instr    (decInstr),
    .i_pop      (issuePop),
    .o_notEmpty (queueNotEmpty),
    .o_head     (queueHead),
    .o_credit   (o_inCredit)  // Pop acknowledge goes upstream
  );

  issueStage issueStage_i (
    .i_clk       (i_clk),
    .i_arstN     (i_arstN),
    .i_notEmpty  (queueNotEmpty),
    .i_head      (queueHead),
    .i_outCredit (i_outCredit),
    .o_pop       (issuePop),
    .o_cmdValid  (o_cmdValid),
    .o_func      (o_func),
    .o_rd        (o_rd),
    .o_rs1       (o_rs1),
    .o_rs2       (o_rs2),
    .o_imm       (o_imm),
    .o_pc        (o_pc),
    .o_jump      (o_jump),
    .o_regReq    (o_regReq)
  );

endmodule

// ==== hw/issueStage.sv ====
//////////////////////////////
// Issue stage
// Spends output credits, builds the register
// requirement vector and drives the command
//////////////////////////////

`timescale 1ns/1ns

`include "decode_params.svh"

module issueStage (
  input  logic                     i_clk,
  input  logic                     i_arstN,
  input  logic                     i_notEmpty,
  input  decodePkg::decodedInstr_t i_head,
  input  logic                     i_outCredit,
  output logic                     o_pop,
  output logic                     o_cmdValid,
  output decodePkg::func_t         o_func,
  output decodePkg::regIdx_t       o_rd,
  output decodePkg::regIdx_t       o_rs1,
  output decodePkg::regIdx_t       o_rs2,
  output decodePkg::xlen_t         o_imm,
  output decodePkg::xlen_t         o_pc,
  output logic                     o_jump,
  output decodePkg::regMask_t      o_regReq
);

  import decodePkg::*;

  localparam int CREDIT_W = $clog2(`DEC_OUT_CREDITS + 1);

  logic [CREDIT_W-1:0] credits;
  regMask_t            regReq;

  assign o_pop = i_notEmpty && (credits != '0);

  // Jumps stall on every register
  always_comb begin
    regReq             = {$bits(regMask_t){i_head.jump}};
    regReq[i_head.rd]  = 1'b1;
    regReq[i_head.rs1] = 1'b1;
    regReq[i_head.rs2] = 1'b1;
  end

  //////////////////////////////
  // Credit counter
  //////////////////////////////
  always_ff @(posedge i_clk or negedge i_arstN) begin
    if (!i_arstN) begin
      credits    <= CREDIT_W'(`DEC_OUT_CREDITS);
      o_cmdValid <= 1'b0;
    end else begin
      case ({o_pop, i_outCredit})
        2'b10:   credits <= credits - 1'b1;
        2'b01:   credits <= credits + 1'b1;
        default: credits <= credits;  // Spend and return cancel
      endcase
      o_cmdValid <= o_pop;
    end
  end

  always_ff @(posedge i_clk) begin
    if (o_pop) begin
      o_func   <= i_head.func;
      o_rd     <= i_head.rd;
      o_rs1    <= i_head.rs1;
      o_rs2    <= i_head.rs2;
      o_imm    <= i_head.imm;
      o_pc     <= i_head.pc;
      o_jump   <= i_head.jump;
      o_regReq <= regReq;
    end
  end

endmodule

// ==== hw/decodeQueue.sv ====
//////////////////////////////
// Command queue
// In-order FIFO of decoded records, returns one
// upstream credit per pop
//////////////////////////////

`timescale 1ns/1ns

`include "decode_params.svh"

module decodeQueue (
  input  logic                     i_clk,
  input  logic                     i_arstN,
  input  logic                     i_valid,
  input  decodePkg::decodedInstr_t i_instr,
  input  logic                     i_pop,
  output logic                     o_notEmpty,
  output decodePkg::decodedInstr_t o_head,
  output logic                     o_credit
);

  import decodePkg::*;

  localparam int PTR_W = (`DEC_QUEUE_DEPTH > 1) ? $clog2(`DEC_QUEUE_DEPTH) : 1;
  localparam int CNT_W = $clog2(`DEC_QUEUE_DEPTH + 1);

  decodedInstr_t    slots [`DEC_QUEUE_DEPTH];
  logic [PTR_W-1:0] wrPtr;
  logic [PTR_W-1:0] rdPtr;
  logic [CNT_W-1:0] count;
  logic             doPop;

  function automatic logic [PTR_W-1:0] nextPtr(input logic [PTR_W-1:0] ptr);
    if (ptr == PTR_W'(`DEC_QUEUE_DEPTH - 1)) return '0;
    return ptr + 1'b1;
  endfunction

  assign o_notEmpty = (count != '0);
  assign o_head     = slots[rdPtr];
  assign doPop      = i_pop && o_notEmpty;  // Ignore a pop on empty

  // Upstream credits keep writes within the free slots
  always_ff @(posedge i_clk) begin
    if (i_valid) slots[wrPtr] <= i_instr;
  end

  always_ff @(posedge i_clk or negedge i_arstN) begin
    if (!i_arstN) begin
      wrPtr    <= '0;
      rdPtr    <= '0;
      count    <= '0;
      o_credit <= 1'b0;
    end else begin
      if (i_valid) wrPtr <= nextPtr(wrPtr);
      if (doPop) rdPtr <= nextPtr(rdPtr);
      case ({i_valid, doPop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
      o_credit <= doPop;  // One cycle after the pop
    end
  end

endmodule

// ==== hw/decodeStage.sv ====
//////////////////////////////
// Decode stage
// Decodes an accepted instruction word
// and registers the command record
//////////////////////////////

`timescale 1ns/1ns

module decodeStage (
  input  logic                     i_clk,
  input  logic                     i_arstN,
  input  logic                     i_instrValid,
  input  decodePkg::xlen_t         i_pc,
  input  decodePkg::instr_t        i_code,
  output logic                     o_valid,
  output decodePkg::decodedInstr_t o_instr
);

  import decodePkg::*;

  func_t         func;
  immSel_t       immSel;
  logic          useRd;
  logic          useRs1;
  logic          useRs2;
  logic          jump;
  xlen_t         imm;
  decodedInstr_t record;

  instrMatch instrMatch_i (
    .i_code   (i_code),
    .o_func   (func),
    .o_immSel (immSel),
    .o_useRd  (useRd),
    .o_useRs1 (useRs1),
    .o_useRs2 (useRs2),
    .o_jump   (jump)
  );

  immGen immGen_i (
    .i_code   (i_code),
    .i_immSel (immSel),
    .o_imm    (imm)
  );

  // Unused register fields read as x0
  always_comb begin
    record.func = func;
    record.rd   = useRd ? regIdx_t'(i_code[11:7]) : '0;
    record.rs1  = useRs1 ? regIdx_t'(i_code[19:15]) : '0;
    record.rs2  = useRs2 ? regIdx_t'(i_code[24:20]) : '0;
    record.imm  = imm;
    record.pc   = i_pc;
    record.jump = jump;
  end

  always_ff @(posedge i_clk or negedge i_arstN) begin
    if (!i_arstN) o_valid <= 1'b0;
    else          o_valid <= i_instrValid;
  end

  always_ff @(posedge i_clk) begin
    if (i_instrValid) o_instr <= record;
  end

endmodule

// ==== hw/immGen.sv ====
//////////////////////////////
// Immediate generator
// Builds every immediate layout and picks one
//////////////////////////////

`timescale 1ns/1ns

`include "decode_params.svh"

module immGen (
  input  decodePkg::instr_t  i_code,
  input  decodePkg::immSel_t i_immSel,
  output decodePkg::xlen_t   o_imm
);

  import decodePkg::*;

  logic  sign;
  xlen_t shamtImm;
  xlen_t bImm;
  xlen_t csrImm;
  xlen_t iImm;
  xlen_t jImm;
  xlen_t sImm;
  xlen_t uImm;

  assign sign = i_code[31];

  assign shamtImm = {{(`DEC_XLEN-6){1'b0}}, i_code[25:20]};
  assign bImm = {{(`DEC_XLEN-12){sign}}, i_code[7], i_code[30:25], i_code[11:8], 1'b0};
  assign csrImm = {{(`DEC_XLEN-17){1'b0}}, i_code[19:15], i_code[31:20]};  // uimm above csr
  assign iImm = {{(`DEC_XLEN-12){sign}}, i_code[31:20]};
  assign jImm = {{(`DEC_XLEN-20){sign}}, i_code[19:12], i_code[20], i_code[30:21], 1'b0};
  assign sImm = {{(`DEC_XLEN-12){sign}}, i_code[31:25], i_code[11:7]};
  assign uImm = {{(`DEC_XLEN-20){1'b0}}, i_code[31:12]};  // Not shifted up

  always_comb begin
    case (i_immSel)
      IMM_SHAMT: o_imm = shamtImm;
      IMM_B:     o_imm = bImm;
      IMM_CSR:   o_imm = csrImm;
      IMM_I:     o_imm = iImm;
      IMM_J:     o_imm = jImm;
      IMM_S:     o_imm = sImm;
      IMM_U:     o_imm = uImm;
      default:   o_imm = '0;
    endcase
  end

endmodule

// ==== hw/instrMatch.sv ====
//////////////////////////////
// Instruction pattern matcher
// Mask and compare table giving the function,
// immediate layout and register-use flags
//////////////////////////////

`timescale 1ns/1ns

module instrMatch (
  input  decodePkg::instr_t  i_code,
  output decodePkg::func_t   o_func,
  output decodePkg::immSel_t o_immSel,
  output logic               o_useRd,
  output logic               o_useRs1,
  output logic               o_useRs2,
  output logic               o_jump
);

  import decodePkg::*;

  typedef struct packed {
    instr_t     mask;
    instr_t     pattern;
    func_t      func;
    immSel_t    immSel;
    logic [3:0] flags;  // {rd, rs1, rs2, jump}
  } tableEntry_t;

  // Flag groups
  localparam logic [3:0] FLG_NONE = 4'b0000;
  localparam logic [3:0] FLG_SYS  = 4'b0001;
  localparam logic [3:0] FLG_U    = 4'b1000;
  localparam logic [3:0] FLG_JAL  = 4'b1001;
  localparam logic [3:0] FLG_JALR = 4'b1101;
  localparam logic [3:0] FLG_B    = 4'b0111;
  localparam logic [3:0] FLG_S    = 4'b0110;
  localparam logic [3:0] FLG_I    = 4'b1100;
  localparam logic [3:0] FLG_R    = 4'b1110;

  localparam int NUM_ENTRIES = 71;

  //////////////////////////////
  // Encoding table
  //////////////////////////////
  localparam tableEntry_t DECODE_TABLE [NUM_ENTRIES] = '{
    '{32'h0000007F, 32'h00000037, FUNC_LUI, IMM_U, FLG_U},
    '{32'h0000007F, 32'h00000017, FUNC_AUIPC, IMM_U, FLG_U},
    '{32'h0000007F, 32'h0000006F, FUNC_JAL, IMM_J, FLG_JAL},
    '{32'h0000707F, 32'h00000067, FUNC_JALR, IMM_I, FLG_JALR},
    '{32'h0000707F, 32'h00000063, FUNC_BEQ, IMM_B, FLG_B},
    '{32'h0000707F, 32'h00001063, FUNC_BNE, IMM_B, FLG_B},
    '{32'h0000707F, 32'h00004063, FUNC_BLT, IMM_B, FLG_B},
    '{32'h0000707F, 32'h00005063, FUNC_BGE, IMM_B, FLG_B},
    '{32'h0000707F, 32'h00006063, FUNC_BLTU, IMM_B, FLG_B},
    '{32'h0000707F, 32'h00007063, FUNC_BGEU, IMM_B, FLG_B},
    '{32'h0000707F, 32'h00000003, FUNC_LB, IMM_I, FLG_I},
    '{32'h0000707F, 32'h00001003, FUNC_LH, IMM_I, FLG_I},
    '{32'h0000707F, 32'h00002003, FUNC_LW, IMM_I, FLG_I},
    '{32'h0000707F, 32'h00004003, FUNC_LBU, IMM_I, FLG_I},
    '{32'h0000707F, 32'h00005003, FUNC_LHU, IMM_I, FLG_I},
    '{32'h0000707F, 32'h00000023, FUNC_SB, IMM_S, FLG_S},
    '{32'h0000707F, 32'h00001023, FUNC_SH, IMM_S, FLG_S},
    '{32'h0000707F, 32'h00002023, FUNC_SW, IMM_S, FLG_S},
    '{32'h0000707F, 32'h00000013, FUNC_ADDI, IMM_I, FLG_I},
    '{32'h0000707F, 32'h00002013, FUNC_SLTI, IMM_I, FLG_I},
    '{32'h0000707F, 32'h00003013, FUNC_SLTIU, IMM_I, FLG_I},
    '{32'h0000707F, 32'h00004013, FUNC_XORI, IMM_I, FLG_I},
    '{32'h0000707F, 32'h00006013, FUNC_ORI, IMM_I, FLG_I},
    '{32'h0000707F, 32'h00007013, FUNC_ANDI, IMM_I, FLG_I},
    '{32'hFC00707F, 32'h00001013, FUNC_SLLI, IMM_SHAMT, FLG_I},  // Six-bit shamt
    '{32'hFC00707F, 32'h00005013, FUNC_SRLI, IMM_SHAMT, FLG_I},
    '{32'hFC00707F, 32'h40005013, FUNC_SRAI, IMM_SHAMT, FLG_I},
    '{32'hFE00707F, 32'h00000033, FUNC_ADD, IMM_NONE, FLG_R},
    '{32'hFE00707F, 32'h40000033, FUNC_SUB, IMM_NONE, FLG_R},
    '{32'hFE00707F, 32'h00001033, FUNC_SLL, IMM_NONE, FLG_R},
    '{32'hFE00707F, 32'h00002033, FUNC_SLT, IMM_NONE, FLG_R},
    '{32'hFE00707F, 32'h00003033, FUNC_SLTU, IMM_NONE, FLG_R},
    '{32'hFE00707F, 32'h00004033, FUNC_XOR, IMM_NONE, FLG_R},
    '{32'hFE00707F, 32'h00005033, FUNC_SRL, IMM_NONE, FLG_R},
    '{32'hFE00707F, 32'h40005033, FUNC_SRA, IMM_NONE, FLG_R},
    '{32'hFE00707F, 32'h00006033, FUNC_OR, IMM_NONE, FLG_R},
    '{32'hFE00707F, 32'h00007033, FUNC_AND, IMM_NONE, FLG_R},
    '{32'h0000707F, 32'h0000000F, FUNC_FENCE, IMM_I, FLG_NONE},  // Covers TSO and PAUSE
    '{32'hFFFFFFFF, 32'h00000073, FUNC_ECALL, IMM_NONE, FLG_SYS},
    '{32'hFFFFFFFF, 32'h00100073, FUNC_EBREAK, IMM_NONE, FLG_SYS},
    '{32'h0000707F, 32'h00006003, FUNC_LWU, IMM_I, FLG_I},
    '{32'h0000707F, 32'h00003003, FUNC_LD, IMM_I, FLG_I},
    '{32'h0000707F, 32'h00003023, FUNC_SD, IMM_S, FLG_S},
    '{32'h0000707F, 32'h0000001B, FUNC_ADDIW, IMM_I, FLG_I},
    '{32'hFE00707F, 32'h0000101B, FUNC_SLLIW, IMM_SHAMT, FLG_I},
    '{32'hFE00707F, 32'h0000501B, FUNC_SRLIW, IMM_SHAMT, FLG_I},
    '{32'hFE00707F, 32'h4000501B, FUNC_SRAIW, IMM_SHAMT, FLG_I},
    '{32'hFE00707F, 32'h0000003B, FUNC_ADDW, IMM_NONE, FLG_R},
    '{32'hFE00707F, 32'h4000003B, FUNC_SUBW, IMM_NONE, FLG_R},
    '{32'hFE00707F, 32'h0000103B, FUNC_SLLW, IMM_NONE, FLG_R},
    '{32'hFE00707F, 32'h0000503B, FUNC_SRLW, IMM_NONE, FLG_R},
    '{32'hFE00707F, 32'h4000503B, FUNC_SRAW, IMM_NONE, FLG_R},
    '{32'h0000707F, 32'h00001073, FUNC_CSRRW, IMM_CSR, FLG_I},
    '{32'h0000707F, 32'h00002073, FUNC_CSRRS, IMM_CSR, FLG_I},
    '{32'h0000707F, 32'h00003073, FUNC_CSRRC, IMM_CSR, FLG_I},
    '{32'h0000707F, 32'h00005073, FUNC_CSRRWI, IMM_CSR, FLG_U},
    '{32'h0000707F, 32'h00006073, FUNC_CSRRSI, IMM_CSR, FLG_U},
    '{32'h0000707F, 32'h00007073, FUNC_CSRRCI, IMM_CSR, FLG_U},
    '{32'hFE00707F, 32'h02000033, FUNC_MUL, IMM_NONE, FLG_R},
    '{32'hFE00707F, 32'h02001033, FUNC_MULH, IMM_NONE, FLG_R},
    '{32'hFE00707F, 32'h02002033, FUNC_MULHSU, IMM_NONE, FLG_R},
    '{32'hFE00707F, 32'h02003033, FUNC_MULHU, IMM_NONE, FLG_R},
    '{32'hFE00707F, 32'h02004033, FUNC_DIV, IMM_NONE, FLG_R},
    '{32'hFE00707F, 32'h02005033, FUNC_DIVU, IMM_NONE, FLG_R},
    '{32'hFE00707F, 32'h02006033, FUNC_REM, IMM_NONE, FLG_R},
    '{32'hFE00707F, 32'h02007033, FUNC_REMU, IMM_NONE, FLG_R},
    '{32'hFE00707F, 32'h0200003B, FUNC_MULW, IMM_NONE, FLG_R},
    '{32'hFE00707F, 32'h0200403B, FUNC_DIVW, IMM_NONE, FLG_R},
    '{32'hFE00707F, 32'h0200503B, FUNC_DIVUW, IMM_NONE, FLG_R},
    '{32'hFE00707F, 32'h0200603B, FUNC_REMW, IMM_NONE, FLG_R},
    '{32'hFE00707F, 32'h0200703B, FUNC_REMUW, IMM_NONE, FLG_R}
  };

  logic [3:0] flags;

  // Entries never overlap, so at most one hits
  always_comb begin
    o_func   = FUNC_INVALID;
    o_immSel = IMM_NONE;
    flags    = FLG_NONE;
    for (int i = 0; i < NUM_ENTRIES; i++) begin
      if ((i_code & DECODE_TABLE[i].mask) == DECODE_TABLE[i].pattern) begin
        o_func   = DECODE_TABLE[i].func;
        o_immSel = DECODE_TABLE[i].immSel;
        flags    = DECODE_TABLE[i].flags;
      end
    end
  end

  assign o_useRd  = flags[3];
  assign o_useRs1 = flags[2];
  assign o_useRs2 = flags[1];
  assign o_jump   = flags[0];

endmodule

// ==== hw/decodePkg.sv ====
//////////////////////////////
// Decode pipeline types
// Function and immediate-select codes,
// vector types and the command record
//////////////////////////////

`include "decode_params.svh"

package decodePkg;

  typedef logic [`DEC_INSTR_W-1:0] instr_t;
  typedef logic [`DEC_XLEN-1:0] xlen_t;  // pc or immediate
  typedef logic [`DEC_REG_W-1:0] regIdx_t;
  typedef logic [(1 << `DEC_REG_W)-1:0] regMask_t;  // One bit per integer register

  // One code per RV64I, M and Zicsr instruction
  typedef enum logic [7:0] {
    FUNC_LUI, FUNC_AUIPC, FUNC_JAL, FUNC_JALR,
    FUNC_BEQ, FUNC_BNE, FUNC_BLT, FUNC_BGE, FUNC_BLTU, FUNC_BGEU,
    FUNC_LB, FUNC_LH, FUNC_LW, FUNC_LBU, FUNC_LHU,
    FUNC_SB, FUNC_SH, FUNC_SW,
    FUNC_ADDI, FUNC_SLTI, FUNC_SLTIU, FUNC_XORI, FUNC_ORI, FUNC_ANDI,
    FUNC_SLLI, FUNC_SRLI, FUNC_SRAI,
    FUNC_ADD, FUNC_SUB, FUNC_SLL, FUNC_SLT, FUNC_SLTU,
    FUNC_XOR, FUNC_SRL, FUNC_SRA, FUNC_OR, FUNC_AND,
    FUNC_FENCE, FUNC_ECALL, FUNC_EBREAK,
    FUNC_LWU, FUNC_LD, FUNC_SD,
    FUNC_ADDIW, FUNC_SLLIW, FUNC_SRLIW, FUNC_SRAIW,
    FUNC_ADDW, FUNC_SUBW, FUNC_SLLW, FUNC_SRLW, FUNC_SRAW,
    FUNC_CSRRW, FUNC_CSRRS, FUNC_CSRRC,
    FUNC_CSRRWI, FUNC_CSRRSI, FUNC_CSRRCI,
    FUNC_MUL, FUNC_MULH, FUNC_MULHSU, FUNC_MULHU,
    FUNC_DIV, FUNC_DIVU, FUNC_REM, FUNC_REMU,
    FUNC_MULW, FUNC_DIVW, FUNC_DIVUW, FUNC_REMW, FUNC_REMUW,
    FUNC_INVALID = 8'hFF  // No pattern matched
  } func_t;

  // Immediate layout
  typedef enum logic [2:0] {
    IMM_NONE,
    IMM_SHAMT,
    IMM_B,
    IMM_CSR,
    IMM_I,
    IMM_J,
    IMM_S,
    IMM_U
  } immSel_t;

  //////////////////////////////
  // Command record
  //////////////////////////////
  typedef struct packed {
    func_t   func;
    regIdx_t rd;
    regIdx_t rs1;
    regIdx_t rs2;
    xlen_t   imm;
    xlen_t   pc;
    logic    jump;  // May redirect the pc
  } decodedInstr_t;

endpackage

// ==== hw/decode_params.svh ====
//////////////////////////////
// Decode pipeline sizes
// Instruction, data and register index widths,
// queue depth and issue credits
//////////////////////////////

`ifndef DECODE_PARAMS_SVH
`define DECODE_PARAMS_SVH

// Datapath widths
`define DEC_INSTR_W 32
`define DEC_XLEN 64
`define DEC_REG_W 5

// Flow control
`define DEC_QUEUE_DEPTH 4 // Also the upstream credits after reset
`define DEC_OUT_CREDITS 2

`endif
